/* Makefile */
# Verilator flow for the mmu_xlat project

VERILATOR ?= verilator
TOP       ?= tb_mmu_top
FILELIST  ?= mmu_xlat.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* mmu_xlat.f */
+incdir+rtl
rtl/mmu_pkg.sv
rtl/mmu_ifs.sv
rtl/mmu_csr.sv
rtl/tlb.sv
rtl/addr_xlat.sv
rtl/mmu_top.sv
sim/tb_mmu_top.sv

/* rtl/addr_xlat.sv */
`include "mmu_cfg.svh"

module addr_xlat
    import mmu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    xlat_cfg_if.xlat        cfg,
    tlb_lookup_if.requester s0,
    input  logic            req_valid_i,
    input  vaddr_t          req_vaddr_i,
    input  acc_type_e       req_type_i,
    output logic            resp_valid_o,
    output paddr_t          resp_paddr_o,
    output ecode_t          resp_ecode_o
);
    logic   direct;
    logic   dmw0_hit;
    logic   dmw1_hit;
    paddr_t paddr_n;
    ecode_t ecode_n;

    // window needs a vseg match and its enable bit for the current plv
    function automatic logic dmw_hit(csr_word_t dmw, vaddr_t va, plv_t plv);
        return dmw[31:29] == va[31:29] && dmw[plv];
    endfunction

    assign direct   = cfg.da || !cfg.pg;
    assign dmw0_hit = dmw_hit(cfg.dmw0, req_vaddr_i, cfg.plv);
    assign dmw1_hit = dmw_hit(cfg.dmw1, req_vaddr_i, cfg.plv);

    assign s0.vppn     = req_vaddr_i[31:13];
    assign s0.va_bit12 = req_vaddr_i[12];
    assign s0.asid     = cfg.asid;

    always_comb begin
        paddr_n = '0;
        ecode_n = `MMU_EC_NONE;
        if (req_type_i == ACC_FETCH && req_vaddr_i[1:0] != 2'b00) begin
            ecode_n = `MMU_EC_ADEF;
        end else if (direct) begin
            paddr_n = req_vaddr_i;
        end else if (dmw0_hit) begin
            paddr_n = {cfg.dmw0[27:25], req_vaddr_i[28:0]};
        end else if (dmw1_hit) begin
            paddr_n = {cfg.dmw1[27:25], req_vaddr_i[28:0]};
        end else if (!s0.found) begin
            ecode_n = `MMU_EC_TLBR;
        end else if (!s0.v) begin
            case (req_type_i)
                ACC_FETCH: ecode_n = `MMU_EC_PIF;
                ACC_LOAD:  ecode_n = `MMU_EC_PIL;
                default:   ecode_n = `MMU_EC_PIS;
            endcase
        end else if (cfg.plv > s0.plv) begin
            ecode_n = `MMU_EC_PPI;
        end else if (req_type_i == ACC_STORE && !s0.d) begin
            ecode_n = `MMU_EC_PME;
        end else begin
            paddr_n = {s0.ppn, req_vaddr_i[11:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        resp_paddr_o <= paddr_n;
        resp_ecode_o <= ecode_n;
    end

    // a faulting response carries no address
    assert property (@(posedge clk) disable iff (reset)
        resp_valid_o && resp_ecode_o != `MMU_EC_NONE |-> resp_paddr_o == '0);

endmodule

/* rtl/mmu_cfg.svh */
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// tlb geometry
`define MMU_TLB_NUM      16

// apb register offsets
`define MMU_REG_CRMD     8'h00
`define MMU_REG_ASID     8'h04
`define MMU_REG_TLBEHI   8'h08
`define MMU_REG_TLBELO0  8'h0C
`define MMU_REG_TLBELO1  8'h10
`define MMU_REG_TLBIDX   8'h14
`define MMU_REG_DMW0     8'h18
`define MMU_REG_DMW1     8'h1C
`define MMU_REG_TLBCMD   8'h20

// command codes in TLBCMD bits 2:0
`define MMU_CMD_SRCH     3'd1
`define MMU_CMD_RD       3'd2
`define MMU_CMD_WR       3'd3
`define MMU_CMD_INV      3'd4

// exception codes
`define MMU_EC_NONE      6'h00
`define MMU_EC_PIL       6'h01
`define MMU_EC_PIS       6'h02
`define MMU_EC_PIF       6'h03
`define MMU_EC_PME       6'h04
`define MMU_EC_PPI       6'h07
`define MMU_EC_ADEF      6'h08
`define MMU_EC_TLBR      6'h3F

`endif

/* rtl/mmu_csr.sv */
`include "mmu_cfg.svh"

module mmu_csr
    import mmu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            psel_i,
    input  logic            penable_i,
    input  logic            pwrite_i,
    input  apb_addr_t       paddr_i,
    input  csr_word_t       pwdata_i,
    output csr_word_t       prdata_o,
    output logic            pready_o,
    output logic            pslverr_o,
    tlb_lookup_if.requester s1,
    tlb_mgmt_if.csr         mgmt,
    xlat_cfg_if.csr         cfg
);
    localparam int IW = $bits(tlb_idx_t);

    // writable bits of each register
    localparam csr_word_t CRMD_MASK   = 32'h0000_001B;
    localparam csr_word_t ASID_MASK   = 32'h0000_03FF;
    localparam csr_word_t TLBEHI_MASK = 32'hFFFF_E000;
    localparam csr_word_t TLBELO_MASK = 32'h0FFF_FF7F;
    localparam csr_word_t TLBIDX_MASK = 32'hBF00_000F;
    localparam csr_word_t DMW_MASK    = 32'hEE00_003F;

    csr_state_e state;
    csr_word_t  crmd;
    csr_word_t  asid;
    csr_word_t  tlbehi;
    csr_word_t  tlbidx;
    csr_word_t  dmw0;
    csr_word_t  dmw1;
    csr_word_t  elo [2];

    logic       access;
    logic       is_cmd;
    logic       addr_ok;
    logic       cmd_bad;
    logic       cmd_write;
    logic       cmd_fire;
    logic [2:0] cmd;
    inv_op_t    op;

    assign access    = psel_i && penable_i;
    assign is_cmd    = paddr_i == `MMU_REG_TLBCMD;
    assign cmd       = pwdata_i[2:0];
    assign op        = pwdata_i[7:3];
    assign cmd_bad   = !(cmd inside {`MMU_CMD_SRCH, `MMU_CMD_RD, `MMU_CMD_WR, `MMU_CMD_INV})
                       || (cmd == `MMU_CMD_INV && op > 5'd6);
    assign cmd_write = access && pwrite_i && is_cmd;
    assign cmd_fire  = cmd_write && state == CSR_IDLE && !cmd_bad;

    // commands complete in the second access cycle
    assign pready_o  = access && (!cmd_write || state == CSR_CMD);
    assign pslverr_o = pready_o && (!addr_ok || (is_cmd && (!pwrite_i || cmd_bad)));

    always_comb begin
        addr_ok  = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `MMU_REG_CRMD:    prdata_o = crmd;
            `MMU_REG_ASID:    prdata_o = asid;
            `MMU_REG_TLBEHI:  prdata_o = tlbehi;
            `MMU_REG_TLBELO0: prdata_o = elo[0];
            `MMU_REG_TLBELO1: prdata_o = elo[1];
            `MMU_REG_TLBIDX:  prdata_o = tlbidx;
            `MMU_REG_DMW0:    prdata_o = dmw0;
            `MMU_REG_DMW1:    prdata_o = dmw1;
            `MMU_REG_TLBCMD:  prdata_o = '0;
            default:          addr_ok  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CSR_IDLE;
        end else if (state == CSR_IDLE && cmd_write) begin
            state <= CSR_CMD;
        end else begin
            state <= CSR_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd   <= 32'h0000_0008;
            asid   <= '0;
            tlbehi <= '0;
            tlbidx <= '0;
            dmw0   <= '0;
            dmw1   <= '0;
            elo[0] <= '0;
            elo[1] <= '0;
        end else if (access && pwrite_i && !is_cmd) begin
            case (paddr_i)
                `MMU_REG_CRMD:    crmd   <= pwdata_i & CRMD_MASK;
                `MMU_REG_ASID:    asid   <= pwdata_i & ASID_MASK;
                `MMU_REG_TLBEHI:  tlbehi <= pwdata_i & TLBEHI_MASK;
                `MMU_REG_TLBELO0: elo[0] <= pwdata_i & TLBELO_MASK;
                `MMU_REG_TLBELO1: elo[1] <= pwdata_i & TLBELO_MASK;
                `MMU_REG_TLBIDX:  tlbidx <= pwdata_i & TLBIDX_MASK;
                `MMU_REG_DMW0:    dmw0   <= pwdata_i & DMW_MASK;
                `MMU_REG_DMW1:    dmw1   <= pwdata_i & DMW_MASK;
                default: ;
            endcase
        end else if (cmd_fire) begin
            case (cmd)
                `MMU_CMD_SRCH: begin
                    tlbidx[31] <= !s1.found;
                    if (s1.found) begin
                        tlbidx[IW-1:0] <= s1.index;
                    end
                end
                `MMU_CMD_RD: begin
                    tlbidx[31] <= !mgmt.r_e;
                    if (mgmt.r_e) begin
                        tlbehi        <= {mgmt.r_vppn, 13'b0};
                        tlbidx[29:24] <= mgmt.r_ps;
                        asid          <= {22'b0, mgmt.r_asid};
                        for (int p = 0; p < 2; p++) begin
                            elo[p] <= {4'b0, mgmt.r_ppn[p], 1'b0, mgmt.r_g, mgmt.r_mat[p],
                                       mgmt.r_plv[p], mgmt.r_d[p], mgmt.r_v[p]};
                        end
                    end else begin
                        tlbehi        <= '0;
                        tlbidx[29:24] <= '0;
                        asid          <= '0;
                        elo[0]        <= '0;
                        elo[1]        <= '0;
                    end
                end
                default: ;
            endcase
        end
    end

    // search port uses the staged vppn and current asid
    assign s1.vppn     = tlbehi[31:13];
    assign s1.va_bit12 = 1'b0;
    assign s1.asid     = asid[9:0];

    assign mgmt.we      = cmd_fire && cmd == `MMU_CMD_WR;
    assign mgmt.w_index = tlbidx[IW-1:0];
    assign mgmt.w_e     = !tlbidx[31];
    assign mgmt.w_vppn  = tlbehi[31:13];
    assign mgmt.w_ps    = tlbidx[29:24];
    assign mgmt.w_asid  = asid[9:0];
    assign mgmt.w_g     = elo[0][6] && elo[1][6];

    for (genvar p = 0; p < 2; p++) begin : g_page
        assign mgmt.w_ppn[p] = elo[p][27:8];
        assign mgmt.w_mat[p] = elo[p][5:4];
        assign mgmt.w_plv[p] = elo[p][3:2];
        assign mgmt.w_d[p]   = elo[p][1];
        assign mgmt.w_v[p]   = elo[p][0];
    end

    assign mgmt.r_index   = tlbidx[IW-1:0];
    assign mgmt.inv_valid = cmd_fire && cmd == `MMU_CMD_INV;
    assign mgmt.inv_op    = op;
    assign mgmt.inv_asid  = asid[9:0];
    assign mgmt.inv_vppn  = tlbehi[31:13];

    assign cfg.plv  = crmd[1:0];
    assign cfg.da   = crmd[3];
    assign cfg.pg   = crmd[4];
    assign cfg.asid = asid[9:0];
    assign cfg.dmw0 = dmw0;
    assign cfg.dmw1 = dmw1;

    // a command write is answered only after its wait state
    assert property (@(posedge clk) disable iff (reset)
        pready_o |-> psel_i && penable_i && (!cmd_write || $past(cmd_write)));

endmodule

/* rtl/mmu_ifs.sv */
interface tlb_lookup_if
    import mmu_pkg::*;
();
    vppn_t    vppn;
    logic     va_bit12;
    asid_t    asid;
    logic     found;
    tlb_idx_t index;
    ppn_t     ppn;
    plv_t     plv;
    mat_t     mat;
    logic     d;
    logic     v;

    modport requester (
        output vppn, va_bit12, asid,
        input  found, index, ppn, plv, mat, d, v
    );
    modport tlb (
        input  vppn, va_bit12, asid,
        output found, index, ppn, plv, mat, d, v
    );
endinterface

interface tlb_mgmt_if
    import mmu_pkg::*;
();
    // write port with page 0 even and page 1 odd
    logic     we;
    tlb_idx_t w_index;
    logic     w_e;
    vppn_t    w_vppn;
    ps_t      w_ps;
    asid_t    w_asid;
    logic     w_g;
    ppn_t     w_ppn [2];
    plv_t     w_plv [2];
    mat_t     w_mat [2];
    logic     w_d   [2];
    logic     w_v   [2];

    // read port
    tlb_idx_t r_index;
    logic     r_e;
    vppn_t    r_vppn;
    ps_t      r_ps;
    asid_t    r_asid;
    logic     r_g;
    ppn_t     r_ppn [2];
    plv_t     r_plv [2];
    mat_t     r_mat [2];
    logic     r_d   [2];
    logic     r_v   [2];

    // invtlb
    logic     inv_valid;
    inv_op_t  inv_op;
    asid_t    inv_asid;
    vppn_t    inv_vppn;

    modport csr (
        output we, w_index, w_e, w_vppn, w_ps, w_asid, w_g,
        output w_ppn, w_plv, w_mat, w_d, w_v,
        output r_index, inv_valid, inv_op, inv_asid, inv_vppn,
        input  r_e, r_vppn, r_ps, r_asid, r_g, r_ppn, r_plv, r_mat, r_d, r_v
    );
    modport tlb (
        input  we, w_index, w_e, w_vppn, w_ps, w_asid, w_g,
        input  w_ppn, w_plv, w_mat, w_d, w_v,
        input  r_index, inv_valid, inv_op, inv_asid, inv_vppn,
        output r_e, r_vppn, r_ps, r_asid, r_g, r_ppn, r_plv, r_mat, r_d, r_v
    );
endinterface

interface xlat_cfg_if
    import mmu_pkg::*;
();
    plv_t      plv;
    logic      da;
    logic      pg;
    asid_t     asid;
    csr_word_t dmw0;
    csr_word_t dmw1;

    modport csr  (output plv, da, pg, asid, dmw0, dmw1);
    modport xlat (input  plv, da, pg, asid, dmw0, dmw1);
endinterface

/* rtl/mmu_pkg.sv */
`include "mmu_cfg.svh"

package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [5:0]  ps_t;
    typedef logic [$clog2(`MMU_TLB_NUM)-1:0] tlb_idx_t;
    typedef logic [4:0]  inv_op_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [7:0]  apb_addr_t;

    typedef enum logic [1:0] {
        ACC_FETCH,
        ACC_LOAD,
        ACC_STORE
    } acc_type_e;

    // command write holds the bus for one extra cycle
    typedef enum logic {
        CSR_IDLE,
        CSR_CMD
    } csr_state_e;

endpackage

/* rtl/mmu_top.sv */
module mmu_top
    import mmu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // apb slave
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  csr_word_t pwdata_i,
    output csr_word_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    // translation
    input  logic      req_valid_i,
    input  vaddr_t    req_vaddr_i,
    input  acc_type_e req_type_i,
    output logic      resp_valid_o,
    output paddr_t    resp_paddr_o,
    output ecode_t    resp_ecode_o
);
    tlb_lookup_if s0_if ();
    tlb_lookup_if s1_if ();
    tlb_mgmt_if   mgmt_if ();
    xlat_cfg_if   cfg_if ();

    mmu_csr u_csr (
        .clk       (clk),
        .reset     (reset),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .s1        (s1_if),
        .mgmt      (mgmt_if),
        .cfg       (cfg_if)
    );

    tlb u_tlb (
        .clk   (clk),
        .reset (reset),
        .s0    (s0_if),
        .s1    (s1_if),
        .mgmt  (mgmt_if)
    );

    addr_xlat u_xlat (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg_if),
        .s0           (s0_if),
        .req_valid_i  (req_valid_i),
        .req_vaddr_i  (req_vaddr_i),
        .req_type_i   (req_type_i),
        .resp_valid_o (resp_valid_o),
        .resp_paddr_o (resp_paddr_o),
        .resp_ecode_o (resp_ecode_o)
    );

endmodule

/* rtl/tlb.sv */
`include "mmu_cfg.svh"

module tlb
    import mmu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    tlb_lookup_if.tlb s0,
    tlb_lookup_if.tlb s1,
    tlb_mgmt_if.tlb   mgmt
);
    localparam int NUM = `MMU_TLB_NUM;

    logic  tlb_e    [NUM];
    vppn_t tlb_vppn [NUM];
    ps_t   tlb_ps   [NUM];
    asid_t tlb_asid [NUM];
    logic  tlb_g    [NUM];
    ppn_t  tlb_ppn  [NUM][2];
    plv_t  tlb_plv  [NUM][2];
    mat_t  tlb_mat  [NUM][2];
    logic  tlb_d    [NUM][2];
    logic  tlb_v    [NUM][2];

    logic [NUM-1:0] m0;
    logic [NUM-1:0] m1;
    logic [NUM-1:0] asid_eq;
    logic [NUM-1:0] vppn_eq;
    logic [NUM-1:0] inv_hit;
    tlb_idx_t       idx0;
    tlb_idx_t       idx1;

    // only 4 KB pages so ps is not matched
    function automatic logic [NUM-1:0] match(vppn_t vppn, asid_t asid);
        logic [NUM-1:0] m;
        for (int i = 0; i < NUM; i++) begin
            m[i] = tlb_e[i] && tlb_vppn[i] == vppn && (tlb_g[i] || tlb_asid[i] == asid);
        end
        return m;
    endfunction

    function automatic tlb_idx_t encode(logic [NUM-1:0] m);
        tlb_idx_t idx;
        idx = '0;
        for (int i = 0; i < NUM; i++) begin
            if (m[i]) begin
                idx = tlb_idx_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        m0   = match(s0.vppn, s0.asid);
        m1   = match(s1.vppn, s1.asid);
        idx0 = encode(m0);
        idx1 = encode(m1);
    end

    // va bit 12 picks the odd page
    assign s0.found = |m0;
    assign s0.index = idx0;
    assign s0.ppn   = tlb_ppn[idx0][s0.va_bit12];
    assign s0.plv   = tlb_plv[idx0][s0.va_bit12];
    assign s0.mat   = tlb_mat[idx0][s0.va_bit12];
    assign s0.d     = tlb_d[idx0][s0.va_bit12];
    assign s0.v     = tlb_v[idx0][s0.va_bit12];

    assign s1.found = |m1;
    assign s1.index = idx1;
    assign s1.ppn   = tlb_ppn[idx1][s1.va_bit12];
    assign s1.plv   = tlb_plv[idx1][s1.va_bit12];
    assign s1.mat   = tlb_mat[idx1][s1.va_bit12];
    assign s1.d     = tlb_d[idx1][s1.va_bit12];
    assign s1.v     = tlb_v[idx1][s1.va_bit12];

    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            asid_eq[i] = tlb_asid[i] == mgmt.inv_asid;
            vppn_eq[i] = tlb_vppn[i] == mgmt.inv_vppn;
            case (mgmt.inv_op)
                5'd0, 5'd1: inv_hit[i] = 1'b1;
                5'd2:       inv_hit[i] = tlb_g[i];
                5'd3:       inv_hit[i] = !tlb_g[i];
                5'd4:       inv_hit[i] = !tlb_g[i] && asid_eq[i];
                5'd5:       inv_hit[i] = !tlb_g[i] && asid_eq[i] && vppn_eq[i];
                5'd6:       inv_hit[i] = (tlb_g[i] || asid_eq[i]) && vppn_eq[i];
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM; i++) begin
                tlb_e[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM; i++) begin
                if (mgmt.inv_valid && inv_hit[i]) begin
                    tlb_e[i] <= 1'b0;
                end
            end
            if (mgmt.we) begin
                tlb_e[mgmt.w_index] <= mgmt.w_e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mgmt.we) begin
            tlb_vppn[mgmt.w_index] <= mgmt.w_vppn;
            tlb_ps[mgmt.w_index]   <= mgmt.w_ps;
            tlb_asid[mgmt.w_index] <= mgmt.w_asid;
            tlb_g[mgmt.w_index]    <= mgmt.w_g;
            for (int p = 0; p < 2; p++) begin
                tlb_ppn[mgmt.w_index][p] <= mgmt.w_ppn[p];
                tlb_plv[mgmt.w_index][p] <= mgmt.w_plv[p];
                tlb_mat[mgmt.w_index][p] <= mgmt.w_mat[p];
                tlb_d[mgmt.w_index][p]   <= mgmt.w_d[p];
                tlb_v[mgmt.w_index][p]   <= mgmt.w_v[p];
            end
        end
    end

    assign mgmt.r_e    = tlb_e[mgmt.r_index];
    assign mgmt.r_vppn = tlb_vppn[mgmt.r_index];
    assign mgmt.r_ps   = tlb_ps[mgmt.r_index];
    assign mgmt.r_asid = tlb_asid[mgmt.r_index];
    assign mgmt.r_g    = tlb_g[mgmt.r_index];

    for (genvar p = 0; p < 2; p++) begin : g_rd_page
        assign mgmt.r_ppn[p] = tlb_ppn[mgmt.r_index][p];
        assign mgmt.r_plv[p] = tlb_plv[mgmt.r_index][p];
        assign mgmt.r_mat[p] = tlb_mat[mgmt.r_index][p];
        assign mgmt.r_d[p]   = tlb_d[mgmt.r_index][p];
        assign mgmt.r_v[p]   = tlb_v[mgmt.r_index][p];
    end

    // the command register filters out undefined ops
    assert property (@(posedge clk) disable iff (reset)
        mgmt.inv_valid |-> mgmt.inv_op <= 5'd6);

endmodule

/* sim/mmu_vectors.txt */
# W offset wdata pslverr | R offset rdata pslverr (hex)
# X type(0 fetch 1 load 2 store) vaddr paddr ecode (hex)
# register masks and bus errors
W 00 ffffffff 0
R 00 0000001b 0
W 04 ffffffff 0
R 04 000003ff 0
W 08 ffffffff 0
R 08 ffffe000 0
W 0c ffffffff 0
R 0c 0fffff7f 0
W 14 ffffffff 0
R 14 bf00000f 0
W 1c ffffffff 0
R 1c ee00003f 0
R 24 00000000 1
W 40 12345678 1
R 20 00000000 1
W 20 00000000 1
# direct address mode
W 00 00000008 0
X 1 12345678 12345678 00
X 0 80001002 00000000 08
X 2 9abcdef0 9abcdef0 00
# direct mapped windows
W 18 a0000001 0
W 1c a2000009 0
W 00 00000010 0
X 1 a1234568 01234568 00
W 00 00000013 0
X 1 a1234568 21234568 00
W 00 00000011 0
X 1 a1234568 00000000 3f
# tlbwr, tlbsrch, tlbrd on entry 3
W 04 00000005 0
W 08 00400000 0
W 0c 0123451f 0
W 10 0abcde01 0
W 14 0c000003 0
W 20 00000003 0
W 14 00000000 0
W 20 00000001 0
R 14 00000003 0
W 08 00000000 0
W 0c 00000000 0
W 10 00000000 0
W 20 00000002 0
R 08 00400000 0
R 0c 0123451f 0
R 10 0abcde01 0
R 14 0c000003 0
W 08 00800000 0
W 20 00000001 0
R 14 8c000003 0
# tlb translation and page faults
X 1 00400abc 12345abc 00
X 1 00401abc 00000000 07
W 00 00000010 0
X 1 00401abc abcdeabc 00
X 2 00401000 00000000 04
X 2 00400ff0 12345ff0 00
# entry 5 global, even page invalid
W 08 00600000 0
W 0c 01111140 0
W 10 02222243 0
W 14 00000005 0
W 20 00000003 0
X 0 00600000 00000000 03
X 1 00600004 00000000 01
X 2 00600008 00000000 02
X 1 00601010 22222010 00
# entry 7 private to asid 5
W 08 00a00000 0
W 0c 03333303 0
W 14 00000007 0
W 20 00000003 0
W 20 0000003c 1
X 1 00a00010 33333010 00
# invtlb op 5 then op 2 then op 4
W 08 00400000 0
W 20 0000002c 0
X 1 00400abc 00000000 3f
X 1 00a00010 33333010 00
X 1 00601010 22222010 00
W 20 00000014 0
X 1 00601010 00000000 3f
X 1 00a00010 33333010 00
W 20 00000024 0
X 1 00a00010 00000000 3f
W 08 00a00000 0
W 20 00000001 0
R 14 80000007 0

/* sim/tb_mmu_top.sv */
`include "mmu_cfg.svh"

module tb_mmu_top
    import mmu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic      clk;
    logic      reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    csr_word_t pwdata;
    csr_word_t prdata;
    logic      pready;
    logic      pslverr;
    logic      req_valid;
    vaddr_t    req_vaddr;
    acc_type_e req_type;
    logic      resp_valid;
    paddr_t    resp_paddr;
    ecode_t    resp_ecode;

    // one entry per vector line
    logic [7:0]  vec_op [$];
    logic [31:0] vec_a  [$];
    logic [31:0] vec_b  [$];
    logic [31:0] vec_c  [$];
    logic [31:0] vec_d  [$];

    int          cycle_count = 0;
    int          cycle_limit = 0;

    // translation waiting for its response
    logic        x_pending = 1'b0;
    paddr_t      x_exp_paddr;
    ecode_t      x_exp_ecode;

    mmu_top dut (
        .clk          (clk),
        .reset        (reset),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .req_valid_i  (req_valid),
        .req_vaddr_i  (req_vaddr),
        .req_type_i   (req_type),
        .resp_valid_o (resp_valid),
        .resp_paddr_o (resp_paddr),
        .resp_ecode_o (resp_ecode)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input csr_word_t wdata, output csr_word_t rdata,
                                output logic err, output int waits);
        advance_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        advance_cycle();
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        advance_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic register_access(input logic [7:0] op, input logic [31:0] offset,
                                   input logic [31:0] value, input logic [31:0] exp_err);
        csr_word_t rdata;
        logic      err;
        int        waits;
        int        exp_waits;
        // only a write to the command register holds the bus
        exp_waits = (op == "W" && offset[7:0] == `MMU_REG_TLBCMD) ? 1 : 0;
        apb_transfer(op == "W", offset[7:0], (op == "W") ? value : '0, rdata, err, waits);
        if (op == "R") begin
            check_value("prdata_o", rdata, value);
        end
        check_value("pslverr_o", 32'(err), exp_err);
        check_value("pready_o wait cycles", waits, exp_waits);
    endtask

    task automatic check_response();
        check_value("resp_valid_o", 32'(resp_valid), 32'd1);
        check_value("resp_paddr_o", resp_paddr, x_exp_paddr);
        check_value("resp_ecode_o", 32'(resp_ecode), 32'(x_exp_ecode));
        x_pending = 1'b0;
    endtask

    // response is due one cycle after the request
    task automatic issue_translation(input logic [31:0] type_code, input logic [31:0] vaddr,
                                     input logic [31:0] exp_paddr, input logic [31:0] exp_ecode);
        advance_cycle();
        req_valid = 1'b1;
        req_vaddr = vaddr;
        req_type  = acc_type_e'(type_code[1:0]);
        @(negedge clk);
        if (x_pending) begin
            check_response();
        end
        x_pending   = 1'b1;
        x_exp_paddr = exp_paddr;
        x_exp_ecode = exp_ecode[5:0];
    endtask

    task automatic flush_translation();
        if (x_pending) begin
            advance_cycle();
            req_valid = 1'b0;
            @(negedge clk);
            check_response();
        end
    endtask

    initial begin
        int                 fd;
        int                 r;
        logic [7:0]         op_char;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        c;
        logic [31:0]        d;
        logic [8*128-1:0]   rest;

        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_type  = ACC_LOAD;

        fd = $fopen("sim/mmu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/mmu_vectors.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "no vector file");
        end
        while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", op_char);
            if (r == 1) begin
                d = '0;
                if (op_char == "#") begin
                    r = $fgets(rest, fd);
                end else if (op_char == "X") begin
                    r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                end else if (op_char == "W" || op_char == "R") begin
                    r = $fscanf(fd, "%h %h %h", a, b, c);
                    r = (r == 3) ? 4 : 0;
                end else begin
                    r = 0;
                end
                if (r != 4 && op_char != "#") begin
                    $display("malformed line in the vector file, operation '%c'", op_char);
                    $display("Simulation finished: FAIL");
                    $fatal(1, "bad vector file");
                end
                if (op_char != "#") begin
                    vec_op.push_back(op_char);
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_c.push_back(c);
                    vec_d.push_back(d);
                end
            end
        end
        $fclose(fd);
        if (vec_op.size() == 0) begin
            $display("the vector file holds no operations");
            $display("Simulation finished: FAIL");
            $fatal(1, "empty vector file");
        end
        cycle_limit = 4 * vec_op.size() + 100;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // outputs are idle once reset is released
        @(negedge clk);
        check_value("resp_valid_o", 32'(resp_valid), 32'd0);
        check_value("pready_o", 32'(pready), 32'd0);
        check_value("pslverr_o", 32'(pslverr), 32'd0);

        for (int i = 0; i < vec_op.size(); i++) begin
            if (vec_op[i] == "X") begin
                issue_translation(vec_a[i], vec_b[i], vec_c[i], vec_d[i]);
            end else begin
                flush_translation();
                register_access(vec_op[i], vec_a[i], vec_b[i], vec_c[i]);
            end
        end
        flush_translation();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
